// File: hw/bus_slot_timer.sv
// Bus slot sequencer
`timescale 1ns/1ps
`default_nettype none

module bus_slot_timer (
	input  logic                   clk32,
	input  logic                   rst_n,
	output logic                   clk8_en,
	output mac_bus_pkg::bus_slot_t bus_slot
);
	import mac_bus_pkg::*;

	logic [$clog2(CLK8_DIV)-1:0] div_cnt;

	// ------------------------------------------------------------------------
	// clk32 / CLK8_DIV enable
	// ------------------------------------------------------------------------
	always_ff @(posedge clk32) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (clk8_en) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign clk8_en = int'(div_cnt) == CLK8_DIV - 1;  // last cycle of the phase

	// video, cpu, io, cpu and round again
	always_ff @(posedge clk32) begin
		if (!rst_n) begin
			bus_slot <= slot_video;
		end else if (clk8_en) begin
			bus_slot <= bus_slot_t'(bus_slot + 2'd1);  // wraps after slot_cpu_b
		end
	end

endmodule

`default_nettype wire

// File: hw/cpu_bus_ack.sv
// DTACK and VPA generation
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_ack (
	input  logic                   clk32,
	input  logic                   rst_n,
	input  logic                   cpu_as_n,
	input  logic [2:0]             cpu_fc,
	input  logic [23:21]           cpu_addr,
	input  logic                   turbo,
	input  mac_bus_pkg::bus_slot_t bus_slot,
	output logic                   cpu_dtack_n,
	output logic                   cpu_vpa_n
);
	import mac_bus_pkg::*;

	logic io_access;
	logic int_ack;
	logic mem_access;
	logic cpu_slot;
	logic cpu_slot_d;
	logic turbo_dtack_en;
	logic dtack_ready;

	assign io_access  = !cpu_as_n && (cpu_addr == IO_REGION_TAG);
	assign int_ack    = !cpu_as_n && (cpu_fc == INTACK_FC);
	assign mem_access = (cpu_addr == ROM_REGION_TAG) || (cpu_addr[23:22] == RAM_REGION_TAG);
	assign cpu_slot   = (bus_slot == slot_cpu_a) || (bus_slot == slot_cpu_b);

	// ------------------------------------------------------------------------
	// turbo hold-off until the next cpu slot
	// ------------------------------------------------------------------------
	always_ff @(posedge clk32) begin
		if (!rst_n) begin
			cpu_slot_d     <= 1'b0;
			turbo_dtack_en <= 1'b0;
		end else begin
			cpu_slot_d <= cpu_slot;
			if (cpu_as_n) begin
				turbo_dtack_en <= 1'b0;  // cycle over
			end else if (cpu_slot && !cpu_slot_d) begin
				turbo_dtack_en <= 1'b1;
			end
		end
	end

	// non-memory accesses never wait for a slot
	assign dtack_ready = !turbo || turbo_dtack_en || !mem_access;

	assign cpu_vpa_n   = !(io_access || int_ack);
	assign cpu_dtack_n = !(!cpu_as_n && !io_access && !int_ack && dtack_ready);

endmodule

`default_nettype wire

// File: hw/image_loader.sv
// ROM and disk image loader
`timescale 1ns/1ps
`default_nettype none

module image_loader (
	input  logic                        clk32,
	input  logic                        rst_n,
	input  logic                        dio_download,
	input  mac_media_pkg::dio_index_t   dio_index,
	input  logic [23:0]                 dio_addr,
	input  logic [7:0]                  dio_data,
	input  logic                        dio_wr,
	input  logic [1:0]                  disk_eject,
	input  logic                        clk8_en,
	input  mac_bus_pkg::bus_slot_t      bus_slot,
	output mac_bus_pkg::mem_word_addr_t dl_addr,
	output mac_bus_pkg::bus_word_t      dl_din,
	output logic [1:0]                  dl_ds,
	output logic                        dl_we,
	output logic [1:0]                  disk_inserted,
	output logic [1:0]                  disk_double_sided
);
	import mac_bus_pkg::*;
	import mac_media_pkg::*;

	logic [20:0] word_base;
	logic [20:0] image_word;
	logic        io_slot_end;
	logic        dio_download_d;
	logic        download_end;
	logic [1:0]  disk_done;
	logic [1:0]  disk_ds;
	logic [1:0]  disk_ss;

	// ------------------------------------------------------------------------
	// byte address to sdram word
	// ------------------------------------------------------------------------
	always_comb begin
		case (dio_index)
			DIO_ROM:      word_base = '0;
			DIO_DISK_INT: word_base = DISK_INT_OFFSET;
			default:      word_base = DISK_EXT_OFFSET;
		endcase
	end

	assign image_word = word_base + dio_addr[21:1];

	// payload of the pending write
	always_ff @(posedge clk32) begin
		if (dio_wr) begin
			dl_addr <= {DOWNLOAD_BANK_TAG, image_word};
			dl_din  <= {dio_data, dio_data};      // same byte on both lanes
			dl_ds   <= {~dio_addr[0], dio_addr[0]}; // even byte is the upper lane
		end
	end

	// write waits for the io slot and drops when that slot ends
	assign io_slot_end = clk8_en && (bus_slot == slot_io) && dio_download;

	always_ff @(posedge clk32) begin
		if (!rst_n) begin
			dl_we <= 1'b0;
		end else if (dio_wr) begin
			dl_we <= 1'b1;
		end else if (io_slot_end) begin
			dl_we <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// disk detection from the final size
	// ------------------------------------------------------------------------
	always_ff @(posedge clk32) begin
		if (!rst_n) begin
			dio_download_d <= 1'b0;
		end else begin
			dio_download_d <= dio_download;
		end
	end

	assign download_end = dio_download_d && !dio_download;
	assign disk_done[0] = download_end && (dio_index == DIO_DISK_INT);
	assign disk_done[1] = download_end && (dio_index == DIO_DISK_EXT);

	always_ff @(posedge clk32) begin
		if (!rst_n) begin
			disk_ds <= 2'b00;
			disk_ss <= 2'b00;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (disk_eject[i]) begin  // eject wins over a finishing download
					disk_ds[i] <= 1'b0;
					disk_ss[i] <= 1'b0;
				end else if (disk_done[i]) begin
					disk_ds[i] <= dio_addr[23:1] == DISK_DS_LAST_WORD;
					disk_ss[i] <= dio_addr[23:1] == DISK_SS_LAST_WORD;
				end
			end
		end
	end

	assign disk_inserted     = disk_ds | disk_ss;  // unknown sizes stay out
	assign disk_double_sided = disk_ds;

endmodule

`default_nettype wire

// File: hw/mac_bus_pkg.sv
// CPU bus timing and address map
`default_nettype none

package mac_bus_pkg;

	// ------------------------------------------------------------------------
	// bus slots, one per clk8 tick
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		slot_video,
		slot_cpu_a,
		slot_io,
		slot_cpu_b
	} bus_slot_t;

	typedef logic [24:0] mem_word_addr_t;  // sdram word address
	typedef logic [15:0] bus_word_t;

	localparam int CLK8_DIV = 4;  // clk32 cycles per clk8 enable

	// address bits 23:21
	localparam logic [2:0] IO_REGION_TAG  = 3'b111;  // autovector / peripherals
	localparam logic [2:0] ROM_REGION_TAG = 3'b010;
	localparam logic [1:0] RAM_REGION_TAG = 2'b00;   // bits 23:22, lower 4 MB
	localparam logic [2:0] INTACK_FC      = 3'b111;

	// ram size masks on the word address
	localparam logic [20:0] RAM_MASK_1MB = 21'h07ffff;
	localparam logic [20:0] RAM_MASK_4MB = 21'h1fffff;

	localparam logic [15:0] RESET_HOLD_TICKS = 16'd65535;  // about 8 ms of clk8

endpackage

`default_nettype wire

// File: hw/mac_glue_top.sv
// System glue top level
`timescale 1ns/1ps
`default_nettype none

module mac_glue_top (
	input  logic                        clk32,
	input  logic                        rst_n,
	input  logic                        status_wr,
	input  logic [7:0]                  status_data,
	input  logic                        dio_download,
	input  mac_media_pkg::dio_index_t   dio_index,
	input  logic [23:0]                 dio_addr,
	input  logic [7:0]                  dio_data,
	input  logic                        dio_wr,
	input  logic [1:0]                  disk_eject,
	input  logic                        cpu_as_n,
	input  logic                        cpu_rw,
	input  logic                        cpu_uds_n,
	input  logic                        cpu_lds_n,
	input  logic [2:0]                  cpu_fc,
	input  logic [23:1]                 cpu_addr,
	input  mac_bus_pkg::bus_word_t      cpu_dout,
	input  mac_bus_pkg::bus_word_t      mem_rdata,
	output mac_bus_pkg::mem_word_addr_t mem_addr,
	output mac_bus_pkg::bus_word_t      mem_din,
	output logic [1:0]                  mem_ds,
	output logic                        mem_we,
	output logic                        mem_oe,
	output mac_bus_pkg::bus_word_t      cpu_rdata,
	output logic                        cpu_dtack_n,
	output logic                        cpu_vpa_n,
	output logic                        cpu_reset_n,
	output logic                        clk8_en,
	output mac_bus_pkg::bus_slot_t      bus_slot,
	output logic [1:0]                  disk_inserted,
	output logic [1:0]                  disk_double_sided,
	output logic                        turbo,
	output logic [1:0]                  cpu_type
);
	import mac_bus_pkg::*;

	logic           ram_4mb;
	logic           reset_request;
	logic           config_changed;
	mem_word_addr_t dl_addr;
	bus_word_t      dl_din;
	logic [1:0]     dl_ds;
	logic           dl_we;

	// ------------------------------------------------------------------------
	// configuration and timing
	// ------------------------------------------------------------------------
	mac_status_regs u_status (
		.clk32(clk32), .rst_n(rst_n), .status_wr(status_wr), .status_data(status_data),
		.ram_4mb(ram_4mb), .turbo(turbo), .reset_request(reset_request),
		.cpu_type(cpu_type), .config_changed(config_changed)
	);

	bus_slot_timer u_timer (
		.clk32(clk32), .rst_n(rst_n), .clk8_en(clk8_en), .bus_slot(bus_slot)
	);

	// ------------------------------------------------------------------------
	// memory path
	// ------------------------------------------------------------------------
	image_loader u_loader (
		.clk32(clk32), .rst_n(rst_n), .dio_download(dio_download), .dio_index(dio_index),
		.dio_addr(dio_addr), .dio_data(dio_data), .dio_wr(dio_wr), .disk_eject(disk_eject),
		.clk8_en(clk8_en), .bus_slot(bus_slot), .dl_addr(dl_addr), .dl_din(dl_din),
		.dl_ds(dl_ds), .dl_we(dl_we), .disk_inserted(disk_inserted),
		.disk_double_sided(disk_double_sided)
	);

	memory_port_mux u_mux (
		.dio_download(dio_download), .bus_slot(bus_slot), .dl_addr(dl_addr),
		.dl_din(dl_din), .dl_ds(dl_ds), .dl_we(dl_we), .cpu_addr(cpu_addr),
		.cpu_as_n(cpu_as_n), .cpu_rw(cpu_rw), .cpu_uds_n(cpu_uds_n), .cpu_lds_n(cpu_lds_n),
		.cpu_dout(cpu_dout), .ram_4mb(ram_4mb), .mem_rdata(mem_rdata), .mem_addr(mem_addr),
		.mem_din(mem_din), .mem_ds(mem_ds), .mem_we(mem_we), .mem_oe(mem_oe),
		.cpu_rdata(cpu_rdata)
	);

	// cpu control lines
	cpu_bus_ack u_ack (
		.clk32(clk32), .rst_n(rst_n), .cpu_as_n(cpu_as_n), .cpu_fc(cpu_fc),
		.cpu_addr(cpu_addr[23:21]), .turbo(turbo), .bus_slot(bus_slot),
		.cpu_dtack_n(cpu_dtack_n), .cpu_vpa_n(cpu_vpa_n)
	);

	reset_sequencer u_reset (
		.clk32(clk32), .rst_n(rst_n), .clk8_en(clk8_en), .reset_request(reset_request),
		.config_changed(config_changed), .dio_download(dio_download),
		.dio_index(dio_index), .cpu_reset_n(cpu_reset_n)
	);

endmodule

`default_nettype wire

// File: hw/mac_media_pkg.sv
// Download and disk image constants
`default_nettype none

package mac_media_pkg;

	typedef logic [4:0] dio_index_t;

	// ------------------------------------------------------------------------
	// download indices as sent by the menu controller
	// ------------------------------------------------------------------------
	localparam dio_index_t DIO_ROM      = 5'd0;
	localparam dio_index_t DIO_DISK_INT = 5'd1;
	localparam dio_index_t DIO_DISK_EXT = 5'd2;

	// last word address of a complete image
	// 819200 bytes double sided, 409600 bytes single sided
	localparam logic [22:0] DISK_DS_LAST_WORD = 23'd409599;
	localparam logic [22:0] DISK_SS_LAST_WORD = 23'd204799;

	// ------------------------------------------------------------------------
	// placement in sdram
	// ------------------------------------------------------------------------
	// the os rom sits at word 0, the images follow at fixed word offsets
	localparam logic [20:0] DISK_INT_OFFSET = 21'h080000;  // 512k words
	localparam logic [20:0] DISK_EXT_OFFSET = 21'h100000;  // 1M words

	// upper address bits while a download writes
	localparam logic [3:0] DOWNLOAD_BANK_TAG = 4'b0001;

endpackage

`default_nettype wire

// File: hw/mac_status_regs.sv
// Menu configuration register
`timescale 1ns/1ps
`default_nettype none

module mac_status_regs (
	input  logic       clk32,
	input  logic       rst_n,
	input  logic       status_wr,
	input  logic [7:0] status_data,
	output logic       ram_4mb,
	output logic       turbo,
	output logic       reset_request,
	output logic [1:0] cpu_type,
	output logic       config_changed
);

	logic mem_differs;
	logic cpu_differs;

	// only memory size and cpu type force a restart
	assign mem_differs = status_data[4] != ram_4mb;
	assign cpu_differs = status_data[7:6] != cpu_type;

	always_ff @(posedge clk32) begin
		if (!rst_n) begin
			ram_4mb        <= 1'b0;
			turbo          <= 1'b0;
			reset_request  <= 1'b0;
			cpu_type       <= 2'b00;
			config_changed <= 1'b0;
		end else begin
			config_changed <= status_wr && (mem_differs || cpu_differs);
			if (status_wr) begin
				reset_request <= status_data[0];
				ram_4mb       <= status_data[4];
				turbo         <= status_data[5];
				cpu_type      <= status_data[7:6];
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/memory_port_mux.sv
// SDRAM port arbitration
`timescale 1ns/1ps
`default_nettype none

module memory_port_mux (
	input  logic                        dio_download,
	input  mac_bus_pkg::bus_slot_t      bus_slot,
	input  mac_bus_pkg::mem_word_addr_t dl_addr,
	input  mac_bus_pkg::bus_word_t      dl_din,
	input  logic [1:0]                  dl_ds,
	input  logic                        dl_we,
	input  logic [23:1]                 cpu_addr,
	input  logic                        cpu_as_n,
	input  logic                        cpu_rw,
	input  logic                        cpu_uds_n,
	input  logic                        cpu_lds_n,
	input  mac_bus_pkg::bus_word_t      cpu_dout,
	input  logic                        ram_4mb,
	input  mac_bus_pkg::bus_word_t      mem_rdata,
	output mac_bus_pkg::mem_word_addr_t mem_addr,
	output mac_bus_pkg::bus_word_t      mem_din,
	output logic [1:0]                  mem_ds,
	output logic                        mem_we,
	output logic                        mem_oe,
	output mac_bus_pkg::bus_word_t      cpu_rdata
);
	import mac_bus_pkg::*;

	logic           download_cycle;
	logic           select_rom;
	logic           select_ram;
	logic [20:0]    ram_mask;
	mem_word_addr_t cpu_mem_addr;

	assign download_cycle = dio_download && (bus_slot == slot_io);

	// ------------------------------------------------------------------------
	// cpu address decode
	// ------------------------------------------------------------------------
	assign select_rom = cpu_addr[23:21] == ROM_REGION_TAG;
	assign select_ram = cpu_addr[23:22] == RAM_REGION_TAG;
	assign ram_mask   = ram_4mb ? RAM_MASK_4MB : RAM_MASK_1MB;

	// rom lives above word 0x200000, ram mirrors inside its size
	assign cpu_mem_addr = select_rom ? {3'b000, 1'b1, cpu_addr[21:1]}
	                                 : {4'b0000, cpu_addr[21:1] & ram_mask};

	always_comb begin
		if (download_cycle) begin
			mem_addr  = dl_addr;
			mem_din   = dl_din;
			mem_ds    = dl_ds;
			mem_we    = dl_we;
			mem_oe    = 1'b0;
			cpu_rdata = 16'hffff;  // keeps the screen dark while loading
		end else begin
			mem_addr  = cpu_mem_addr;
			mem_din   = cpu_dout;
			mem_ds    = {~cpu_uds_n, ~cpu_lds_n};
			mem_we    = !cpu_as_n && !cpu_rw && select_ram;  // rom is read only
			mem_oe    = !cpu_as_n && cpu_rw && (select_rom || select_ram);
			cpu_rdata = mem_rdata;
		end
	end

endmodule

`default_nettype wire

// File: hw/reset_sequencer.sv
// CPU reset stretcher
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
	input  logic                      clk32,
	input  logic                      rst_n,
	input  logic                      clk8_en,
	input  logic                      reset_request,
	input  logic                      config_changed,
	input  logic                      dio_download,
	input  mac_media_pkg::dio_index_t dio_index,
	output logic                      cpu_reset_n
);
	import mac_bus_pkg::*;
	import mac_media_pkg::*;

	logic [$bits(RESET_HOLD_TICKS)-1:0] hold_cnt;
	logic                               change_seen;
	logic                               rom_download;
	logic                               reset_cause;

	// keep the single cycle change pulse until the next clk8 tick
	always_ff @(posedge clk32) begin
		if (!rst_n) begin
			change_seen <= 1'b0;
		end else if (config_changed) begin
			change_seen <= 1'b1;
		end else if (clk8_en) begin
			change_seen <= 1'b0;
		end
	end

	assign rom_download = dio_download && (dio_index == DIO_ROM);  // disks load live
	assign reset_cause  = reset_request || config_changed || change_seen || rom_download;

	always_ff @(posedge clk32) begin
		if (!rst_n) begin
			hold_cnt <= RESET_HOLD_TICKS;
		end else if (clk8_en) begin
			if (reset_cause) begin
				hold_cnt <= RESET_HOLD_TICKS;
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end
	end

	assign cpu_reset_n = hold_cnt == '0;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the system glue testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mac_glue -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_mac_glue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
	exit 0
fi
exit 1

// File: sources.f
hw/mac_bus_pkg.sv
hw/mac_media_pkg.sv
hw/mac_status_regs.sv
hw/bus_slot_timer.sv
hw/image_loader.sv
hw/memory_port_mux.sv
hw/cpu_bus_ack.sv
hw/reset_sequencer.sv
hw/mac_glue_top.sv
verification/mac_glue_assertions.sv
verification/tb_mac_glue.sv

// File: verification/mac_glue_assertions.sv
// System glue bus rules
`timescale 1ns/1ps
`default_nettype none

module mac_glue_assertions (
	input logic                        clk32,
	input logic                        rst_n,
	input logic                        mem_we,
	input logic                        mem_oe,
	input mac_bus_pkg::mem_word_addr_t mem_addr,
	input logic                        clk8_en,
	input mac_bus_pkg::bus_slot_t      bus_slot
);
	import mac_bus_pkg::*;
	import mac_media_pkg::*;

	// sdram port never reads and writes at once
	assert property (@(posedge clk32) disable iff (!rst_n) !(mem_we && mem_oe))
		else $error("mem_we and mem_oe high together");

	// download writes only land in the io slot
	// cpu writes stay in ram, so a write into the download bank is a download
	assert property (@(posedge clk32) disable iff (!rst_n)
		(mem_we && mem_addr[24:21] == DOWNLOAD_BANK_TAG) |-> bus_slot == slot_io)
		else $error("download write outside slot_io");

	assert property (@(posedge clk32) disable iff (!rst_n) clk8_en |=> !clk8_en)
		else $error("clk8_en wider than one cycle");

endmodule

bind mac_glue_top mac_glue_assertions u_assertions (
	.clk32(clk32), .rst_n(rst_n), .mem_we(mem_we), .mem_oe(mem_oe),
	.mem_addr(mem_addr), .clk8_en(clk8_en), .bus_slot(bus_slot)
);

`default_nettype wire

// File: verification/tb_mac_glue.sv
// System glue testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mac_glue;
	import mac_bus_pkg::*;
	import mac_media_pkg::*;

	logic clk32 = 1'b0;
	logic rst_n;
	logic status_wr, dio_download, dio_wr, cpu_as_n, cpu_rw, cpu_uds_n, cpu_lds_n;
	logic [7:0] status_data, dio_data;
	dio_index_t dio_index;
	logic [23:0] dio_addr;
	logic [1:0] disk_eject;
	logic [2:0] cpu_fc;
	logic [23:1] cpu_addr;
	bus_word_t cpu_dout, mem_rdata, mem_din, cpu_rdata;
	mem_word_addr_t mem_addr;
	logic [1:0] mem_ds, disk_inserted, disk_double_sided, cpu_type;
	logic mem_we, mem_oe, cpu_dtack_n, cpu_vpa_n, cpu_reset_n, clk8_en, turbo;
	bus_slot_t bus_slot;

	int checks = 0;
	int errors = 0;
	logic [31:0] rng = 32'hb8ff48b6;

	always #2 clk32 = ~clk32;

	mac_glue_top u_dut (.*);

	// ------------------------------------------------------------------------
	// compare and helper tasks
	// ------------------------------------------------------------------------
	task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input mem_word_addr_t got,
	                          input mem_word_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic abort_run(input string what);
		$display("Timeout: %s", what);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic step;  // falling edge, then let outputs settle
		@(negedge clk32);
		#1;
	endtask

	task automatic wait_slot(input bus_slot_t slot);
		int n;
		n = 0;
		while (bus_slot != slot) begin
			step();
			n++;
			if (n > 4 * CLK8_DIV) abort_run("bus slot never came round");
		end
	endtask

	task automatic write_status(input logic [7:0] value);
		@(negedge clk32);
		status_wr   = 1'b1;
		status_data = value;
		@(negedge clk32);
		status_wr = 1'b0;
	endtask

	task automatic report(input string name, input int errs_before);
		if (errors == errs_before) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - errs_before);
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset_state;
		int e0;
		e0 = errors;
		check_bit("mem_we", mem_we, 1'b0);
		check_bit("mem_oe", mem_oe, 1'b0);
		check_bit("disk_inserted[0]", disk_inserted[0], 1'b0);
		check_bit("disk_inserted[1]", disk_inserted[1], 1'b0);
		check_bit("turbo", turbo, 1'b0);
		check_bit("bus_slot is video", bus_slot == slot_video, 1'b1);
		// first enable on the fourth clk32 cycle
		for (int i = 0; i < CLK8_DIV; i++) begin
			check_bit("clk8_en", clk8_en, i == CLK8_DIV - 1);
			step();
		end
		check_bit("bus_slot is cpu_a", bus_slot == slot_cpu_a, 1'b1);
		report("reset_state", e0);
	endtask

	task automatic wait_reset_level(input logic level, input int limit, output int n);
		n = 0;
		while (cpu_reset_n !== level) begin
			step();
			n++;
			if (n > limit) abort_run("cpu_reset_n did not change");
		end
	endtask

	task automatic test_reset_release;
		int e0, n;
		e0 = errors;
		check_bit("cpu_reset_n", cpu_reset_n, 1'b0);
		wait_reset_level(1'b1, int'(RESET_HOLD_TICKS) * CLK8_DIV + 64, n);
		check_bit("release late enough", n >= int'(RESET_HOLD_TICKS) * CLK8_DIV - 8, 1'b1);
		write_status(8'h01);  // menu reset
		wait_reset_level(1'b0, 2 * CLK8_DIV, n);
		write_status(8'h00);
		wait_reset_level(1'b1, int'(RESET_HOLD_TICKS) * CLK8_DIV + 64, n);
		write_status(8'h10);  // memory size change
		wait_reset_level(1'b0, 2 * CLK8_DIV, n);
		report("reset_release", e0);
	endtask

	// exp_addr carries the download bank in bits 24:21
	task automatic test_download(input dio_index_t index, input logic [23:0] addr,
	                             input mem_word_addr_t exp_addr);
		int e0;
		logic [7:0] data;
		e0 = errors;
		rng  = xorshift(rng);
		data = rng[7:0];
		@(negedge clk32);
		dio_download = 1'b1;
		dio_index    = index;
		dio_addr     = addr;
		dio_data     = data;
		dio_wr       = 1'b1;
		@(negedge clk32);
		dio_wr = 1'b0;
		#1;
		wait_slot(slot_io);
		check_addr("mem_addr", mem_addr, exp_addr);
		check_word("mem_din", mem_din, {data, data});
		check_bit("mem_ds[1]", mem_ds[1], !addr[0]);
		check_bit("mem_ds[0]", mem_ds[0], addr[0]);
		check_bit("mem_we", mem_we, 1'b1);
		check_word("cpu_rdata", cpu_rdata, 16'hffff);
		wait_slot(slot_cpu_b);
		@(negedge clk32);
		dio_download = 1'b0;
		report($sformatf("download_idx%0d", index), e0);
	endtask

	task automatic test_disk(input dio_index_t index, input logic [23:0] last,
	                         input int disk, input logic ins, input logic ds);
		int e0;
		e0 = errors;
		@(negedge clk32);
		dio_download = 1'b1;
		dio_index    = index;
		dio_addr     = last;
		@(negedge clk32);
		dio_download = 1'b0;  // final size is decided here
		step();
		check_bit("disk_inserted", disk_inserted[disk], ins);
		check_bit("disk_double_sided", disk_double_sided[disk], ds);
		report($sformatf("disk_detect_%0d", last), e0);
	endtask

	task automatic test_eject(input int disk);
		int e0;
		e0 = errors;
		@(negedge clk32);
		disk_eject[disk] = 1'b1;
		@(negedge clk32);
		disk_eject = 2'b00;
		#1;
		check_bit("disk_inserted", disk_inserted[disk], 1'b0);
		check_bit("other disk_inserted", disk_inserted[1 - disk], 1'b1);
		report("eject", e0);
	endtask

	task automatic test_cpu_decode;
		int e0;
		logic [23:0] rom_byte, ram_byte;
		e0 = errors;
		rom_byte = 24'h401234;
		ram_byte = 24'h180000;  // 1.5 MB
		write_status(8'h00);
		@(negedge clk32);
		cpu_as_n  = 1'b0;
		cpu_rw    = 1'b1;
		cpu_addr  = rom_byte[23:1];
		mem_rdata = 16'hbeef;
		#1;
		check_addr("mem_addr", mem_addr, 25'h200000 | 25'(rom_byte[21:1]));
		check_bit("mem_oe", mem_oe, 1'b1);
		check_word("cpu_rdata", cpu_rdata, 16'hbeef);
		cpu_addr = ram_byte[23:1];
		#1;
		check_addr("mem_addr", mem_addr, 25'h040000);  // folded back into 1 MB
		write_status(8'h10);
		#1;
		check_addr("mem_addr", mem_addr, 25'h0c0000);
		@(negedge clk32);
		cpu_rw    = 1'b0;
		cpu_uds_n = 1'b0;
		cpu_lds_n = 1'b1;
		cpu_dout  = 16'h5a3c;
		#1;
		check_bit("mem_we", mem_we, 1'b1);
		check_bit("mem_oe", mem_oe, 1'b0);
		check_bit("mem_ds[1]", mem_ds[1], 1'b1);
		check_bit("mem_ds[0]", mem_ds[0], 1'b0);
		check_word("mem_din", mem_din, 16'h5a3c);
		@(negedge clk32);
		cpu_as_n  = 1'b1;
		cpu_rw    = 1'b1;
		cpu_uds_n = 1'b1;
		report("cpu_decode", e0);
	endtask

	task automatic test_bus_ack;
		int e0, n;
		logic seen_low;
		e0 = errors;
		@(negedge clk32);
		cpu_as_n = 1'b0;
		cpu_addr = 23'h700000;  // 0xe00000, peripheral space
		#1;
		check_bit("cpu_vpa_n", cpu_vpa_n, 1'b0);
		check_bit("cpu_dtack_n", cpu_dtack_n, 1'b1);
		cpu_addr = 23'h001000;
		cpu_fc   = INTACK_FC;
		#1;
		check_bit("cpu_vpa_n", cpu_vpa_n, 1'b0);
		check_bit("cpu_dtack_n", cpu_dtack_n, 1'b1);
		cpu_fc = 3'b101;
		#1;
		check_bit("cpu_vpa_n", cpu_vpa_n, 1'b1);
		check_bit("cpu_dtack_n", cpu_dtack_n, 1'b0);
		cpu_as_n = 1'b1;
		write_status(8'hb0);  // turbo on, cpu type 2
		check_bit("turbo", turbo, 1'b1);
		check_bit("cpu_type[1]", cpu_type[1], 1'b1);
		check_bit("cpu_type[0]", cpu_type[0], 1'b0);
		// start the access early in a video slot
		wait_slot(slot_cpu_b);
		wait_slot(slot_video);
		@(negedge clk32);
		cpu_as_n = 1'b0;
		#1;
		n = 0;
		while (bus_slot != slot_cpu_a) begin
			check_bit("cpu_dtack_n", cpu_dtack_n, 1'b1);
			step();
			n++;
			if (n > 2 * CLK8_DIV) abort_run("cpu slot never began");
		end
		seen_low = 1'b0;
		n = 0;
		while (bus_slot == slot_cpu_a) begin
			if (cpu_dtack_n == 1'b0) seen_low = 1'b1;
			step();
			n++;
			if (n > 2 * CLK8_DIV) abort_run("cpu slot never ended");
		end
		check_bit("turbo dtack in cpu slot", seen_low, 1'b1);
		@(negedge clk32);
		cpu_as_n = 1'b1;
		report("bus_ack", e0);
	endtask

	// ------------------------------------------------------------------------
	// sequence
	// ------------------------------------------------------------------------
	initial begin
		rst_n = 1'b0;
		status_wr = 1'b0;
		status_data = 8'h00;
		dio_download = 1'b0;
		dio_index = DIO_ROM;
		dio_addr = 24'h0;
		dio_data = 8'h00;
		dio_wr = 1'b0;
		disk_eject = 2'b00;
		cpu_as_n = 1'b1;
		cpu_rw = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		cpu_fc = 3'b101;
		cpu_addr = '0;
		cpu_dout = '0;
		mem_rdata = '0;
		repeat (2) @(negedge clk32);
		rst_n = 1'b1;
		#1;

		test_reset_state();
		test_reset_release();
		test_download(DIO_ROM, 24'h012344, 25'h2091a2);
		test_download(DIO_ROM, 24'h012345, 25'h2091a2);
		test_download(DIO_DISK_INT, 24'h000101, 25'h280080);
		test_download(DIO_DISK_EXT, 24'h0a0002, 25'h350001);
		test_disk(DIO_DISK_INT, 24'd819198, 0, 1'b1, 1'b1);
		test_disk(DIO_DISK_EXT, 24'd409598, 1, 1'b1, 1'b0);
		test_eject(1);
		test_disk(DIO_DISK_INT, 24'd1000, 0, 1'b0, 1'b0);
		test_cpu_decode();
		test_bus_ack();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
